//--- vlog.f
+incdir+.
core_pkg.sv
core_ifs.sv
inst_decoder.sv
operand_select.sv
execute_unit.sv
pipeline_control.sv
register_file.sv
core_top.sv
tb_core.sv

//--- tb_program.svh
    localparam int PROG_LEN  = 33;
    localparam int RET_LEN   = 21;
    localparam int REDIR_LEN = 4;

    inst_t       prog_mem    [PROG_LEN];
    logic [36:0] ret_table   [RET_LEN];
    addr_t       redir_table [REDIR_LEN];

    initial begin
        // word i sits at PC 4*i, NOPs follow past the end
        prog_mem[0]  = 32'h0050_0093;  // addi x1, x0, 5
        prog_mem[1]  = 32'hFFD0_0113;  // addi x2, x0, -3
        prog_mem[2]  = 32'h0020_81B3;  // add  x3, x1, x2
        prog_mem[3]  = 32'h4021_8233;  // sub  x4, x3, x2
        prog_mem[4]  = 32'h0020_C2B3;  // xor  x5, x1, x2
        prog_mem[5]  = 32'h0012_E333;  // or   x6, x5, x1
        prog_mem[6]  = 32'h0043_73B3;  // and  x7, x6, x4
        prog_mem[7]  = 32'h0011_2433;  // slt  x8, x2, x1
        prog_mem[8]  = 32'h0020_A4B3;  // slt  x9, x1, x2
        prog_mem[9]  = 32'h1234_5537;  // lui  x10, 0x12345
        prog_mem[10] = 32'h6785_0513;  // addi x10, x10, 0x678
        prog_mem[11] = 32'hFFF5_4593;  // xori x11, x10, -1
        prog_mem[12] = 32'h0FF5_F613;  // andi x12, x11, 0xff
        prog_mem[13] = 32'hFFE1_2693;  // slti x13, x2, -2
        prog_mem[14] = 32'h0F00_6713;  // ori  x14, x0, 0xf0
        prog_mem[15] = 32'h0070_8013;  // addi x0, x1, 7
        prog_mem[16] = 32'h0010_07B3;  // add  x15, x0, x1
        prog_mem[17] = 32'h8000_0837;  // lui  x16, 0x80000
        prog_mem[18] = 32'hFFF8_0893;  // addi x17, x16, -1
        prog_mem[19] = 32'h0060_8463;  // beq  x1, x6, +8   not taken
        prog_mem[20] = 32'h0020_9663;  // bne  x1, x2, +12  taken
        prog_mem[21] = 32'h0010_0A13;  // addi x20, x0, 1   skipped
        prog_mem[22] = 32'h0020_0A93;  // addi x21, x0, 2   skipped
        prog_mem[23] = 32'h0011_4463;  // blt  x2, x1, +8   taken
        prog_mem[24] = 32'h0030_0B13;  // addi x22, x0, 3   skipped
        prog_mem[25] = 32'h0020_C463;  // blt  x1, x2, +8   not taken
        prog_mem[26] = 32'h00C0_0BEF;  // jal  x23, +12
        prog_mem[27] = 32'h0040_0C13;  // addi x24, x0, 4   skipped
        prog_mem[28] = 32'h0050_0C93;  // addi x25, x0, 5   skipped
        prog_mem[29] = 32'h001B_8D33;  // add  x26, x23, x1
        prog_mem[30] = 32'h0080_006F;  // jal  x0, +8
        prog_mem[31] = 32'h0060_0D93;  // addi x27, x0, 6   skipped
        prog_mem[32] = 32'h411D_0E33;  // sub  x28, x26, x17

        // destination in [36:32], value in [31:0]
        ret_table[0]  = {5'd1,  32'h0000_0005};
        ret_table[1]  = {5'd2,  32'hFFFF_FFFD};
        ret_table[2]  = {5'd3,  32'h0000_0002};
        ret_table[3]  = {5'd4,  32'h0000_0005};
        ret_table[4]  = {5'd5,  32'hFFFF_FFF8};
        ret_table[5]  = {5'd6,  32'hFFFF_FFFD};
        ret_table[6]  = {5'd7,  32'h0000_0005};
        ret_table[7]  = {5'd8,  32'h0000_0001};
        ret_table[8]  = {5'd9,  32'h0000_0000};
        ret_table[9]  = {5'd10, 32'h1234_5000};
        ret_table[10] = {5'd10, 32'h1234_5678};
        ret_table[11] = {5'd11, 32'hEDCB_A987};
        ret_table[12] = {5'd12, 32'h0000_0087};
        ret_table[13] = {5'd13, 32'h0000_0001};
        ret_table[14] = {5'd14, 32'h0000_00F0};
        ret_table[15] = {5'd15, 32'h0000_0005};
        ret_table[16] = {5'd16, 32'h8000_0000};
        ret_table[17] = {5'd17, 32'h7FFF_FFFF};
        ret_table[18] = {5'd23, 32'h0000_006C};
        ret_table[19] = {5'd26, 32'h0000_0071};
        ret_table[20] = {5'd28, 32'h8000_0072};

        // targets of the taken branches and jumps
        redir_table[0] = 32'h0000_005C;
        redir_table[1] = 32'h0000_0064;
        redir_table[2] = 32'h0000_0074;
        redir_table[3] = 32'h0000_0080;
    end

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

    `include "tb_program.svh"

    localparam int          CLK_HALF        = 5;
    localparam int          RESET_CYCLES    = 8;
    localparam int          DRAIN_CYCLES    = 40;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * 40;
    localparam int unsigned SEED            = 32'h35b64f55;

    logic        clk         = 1'b0;
    logic        rst_i       = 1'b1;
    logic        fetch_valid = 1'b0;
    addr_t       fetch_pc    = RESET_PC;
    inst_t       fetch_inst  = INST_NOP;
    logic        fetch_ready;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic        retire_valid;
    reg_idx_t    retire_rd;
    xlen_t       retire_data;

    addr_t       offer_pc  = RESET_PC;
    int          edge_cnt  = 0;
    int          ret_idx   = 0;
    int          redir_idx = 0;
    int          check_cnt = 0;
    int          err_cnt   = 0;
    int unsigned seed_val;

    core_top i_dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .fetch_inst_i     (fetch_inst),
        .fetch_ready_o    (fetch_ready),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .retire_valid_o   (retire_valid),
        .retire_rd_o      (retire_rd),
        .retire_data_o    (retire_data)
    );

    always #CLK_HALF clk = ~clk;

    function automatic inst_t word_at(input addr_t pc);
        int unsigned idx;
        idx = pc >> 2;
        if (idx < PROG_LEN) begin
            return prog_mem[idx];
        end else begin
            return INST_NOP;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] %s: expected 0x%08h, got 0x%08h", name, exp, got);
        err_cnt++;
    endtask

    task automatic expect_quiet_outputs();
        check_cnt++;
        if (retire_valid !== 1'b0) begin
            report_mismatch("retire_valid_o", 32'h0, {31'b0, retire_valid});
        end
        if (redirect_valid !== 1'b0) begin
            report_mismatch("redirect_valid_o", 32'h0, {31'b0, redirect_valid});
        end
        if (fetch_ready !== 1'b1) begin
            report_mismatch("fetch_ready_o", 32'h1, {31'b0, fetch_ready});
        end
    endtask

    task automatic compare_retire();
        reg_idx_t exp_rd;
        xlen_t    exp_data;
        if (ret_idx >= RET_LEN) begin
            $display("extra retire of x%0d with 0x%08h after the expected sequence",
                     retire_rd, retire_data);
            err_cnt++;
        end else begin
            exp_rd   = ret_table[ret_idx][36:32];
            exp_data = ret_table[ret_idx][31:0];
            check_cnt++;
            if (retire_rd !== exp_rd) begin
                report_mismatch("retire_rd_o", {27'b0, exp_rd}, {27'b0, retire_rd});
            end
            if (retire_data !== exp_data) begin
                report_mismatch("retire_data_o", exp_data, retire_data);
            end
            ret_idx++;
        end
    endtask

    task automatic match_redirect();
        if (redir_idx >= REDIR_LEN) begin
            $display("redirect to 0x%08h was not expected", redirect_pc);
            err_cnt++;
        end else begin
            check_cnt++;
            if (redirect_pc !== redir_table[redir_idx]) begin
                report_mismatch("redirect_pc_o", redir_table[redir_idx], redirect_pc);
            end
            redir_idx++;
        end
    endtask

    task automatic print_summary();
        $display("%0d checks, %0d errors, %0d of %0d retires, %0d of %0d redirects",
                 check_cnt, err_cnt, ret_idx, RET_LEN, redir_idx, REDIR_LEN);
    endtask

    // fetch source with random gaps, holds its word while ready is low
    initial begin
        seed_val = SEED;
        seed_val = $urandom(seed_val);
        forever begin
            @(posedge clk);
            if (rst_i) begin
                fetch_valid <= 1'b0;
                offer_pc    <= RESET_PC;
            end else if (redirect_valid) begin
                fetch_valid <= 1'b0;
                offer_pc    <= redirect_pc;
            end else if (!fetch_valid || fetch_ready) begin
                if (($urandom % 4) == 0) begin
                    fetch_valid <= 1'b0;
                end else begin
                    fetch_valid <= 1'b1;
                    fetch_pc    <= offer_pc;
                    fetch_inst  <= word_at(offer_pc);
                    offer_pc    <= offer_pc + PC_STEP;
                end
            end
        end
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        // reset window and the first cycles after release
        if (edge_cnt >= 1 && edge_cnt < RESET_CYCLES + 4) begin
            expect_quiet_outputs();
        end
        if (!rst_i && retire_valid === 1'b1) begin
            compare_retire();
        end
        if (!rst_i && redirect_valid === 1'b1) begin
            match_redirect();
        end
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        while (ret_idx < RET_LEN) begin
            @(posedge clk);
        end
        // catch late extra retires or redirects
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (redir_idx != REDIR_LEN) begin
            $display("saw %0d redirects, expected %0d", redir_idx, REDIR_LEN);
            err_cnt++;
        end
        print_summary();
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, retire sequence incomplete", WATCHDOG_CYCLES);
        err_cnt++;
        print_summary();
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        fetch_valid_i,
    input  addr_t      fetch_pc_i,
    input  inst_t      fetch_inst_i,
    output logic       fetch_ready_o,
    output logic       redirect_valid_o,
    output addr_t      redirect_pc_o,
    output logic       retire_valid_o,
    output reg_idx_t   retire_rd_o,
    output xlen_t      retire_data_o
);

    logic      id_stall;
    logic      ds_stall;
    logic      exe_stall;
    logic      flush_now;
    logic      flush_last;
    logic      id_valid;
    addr_t     id_pc;
    logic      ds_valid;
    addr_t     ds_pc;
    logic      hazard_stall;
    logic      exe_valid;
    logic      exe_resolved;
    reg_idx_t  exe_rd;
    logic      exe_we;
    addr_t     next_pc;

    decode_if  dec_bus ();
    operand_if opd_bus ();
    result_if  res_bus ();
    bypass_if  byp_bus ();

    inst_decoder i_decoder (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_inst_i  (fetch_inst_i),
        .fetch_ready_o (fetch_ready_o),
        .id_stall      (id_stall),
        .flush_now     (flush_now),
        .flush_last    (flush_last),
        .id_valid_o    (id_valid),
        .id_pc_o       (id_pc),
        .dec           (dec_bus.master)
    );

    operand_select i_operand (
        .clk            (clk),
        .rst_i          (rst_i),
        .dec            (dec_bus.slave),
        .ds_stall       (ds_stall),
        .flush_now      (flush_now),
        .hazard_stall_o (hazard_stall),
        .ds_valid_o     (ds_valid),
        .ds_pc_o        (ds_pc),
        .exe_rd_i       (exe_rd),
        .exe_we_i       (exe_we),
        .byp            (byp_bus.reader),
        .opd            (opd_bus.master)
    );

    execute_unit i_execute (
        .clk            (clk),
        .rst_i          (rst_i),
        .opd            (opd_bus.slave),
        .exe_stall      (exe_stall),
        .flush_now      (flush_now),
        .exe_valid_o    (exe_valid),
        .exe_resolved_o (exe_resolved),
        .exe_rd_o       (exe_rd),
        .exe_we_o       (exe_we),
        .next_pc_o      (next_pc),
        .res            (res_bus.master)
    );

    pipeline_control i_control (
        .clk              (clk),
        .rst_i            (rst_i),
        .id_valid_i       (id_valid),
        .id_pc_i          (id_pc),
        .ds_valid_i       (ds_valid),
        .ds_pc_i          (ds_pc),
        .hazard_stall_i   (hazard_stall),
        .exe_valid_i      (exe_valid),
        .exe_resolved_i   (exe_resolved),
        .next_pc_i        (next_pc),
        .id_stall_o       (id_stall),
        .ds_stall_o       (ds_stall),
        .exe_stall_o      (exe_stall),
        .flush_now_o      (flush_now),
        .flush_last_o     (flush_last),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    register_file i_regfile (
        .clk            (clk),
        .rst_i          (rst_i),
        .res            (res_bus.slave),
        .byp            (byp_bus.owner),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    result_if.slave    res,
    bypass_if.owner    byp,
    output logic       retire_valid_o,
    output reg_idx_t   retire_rd_o,
    output xlen_t      retire_data_o
);

    logic      wb_valid;
    reg_idx_t  wb_rd;
    logic      wb_we;
    xlen_t     wb_data;
    logic      wb_write;
    xlen_t     regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= res.rd;
        wb_we   <= res.reg_we;
        wb_data <= res.result;
    end

    assign wb_write = wb_valid && wb_we && (wb_rd != '0);

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 reads as zero
    assign byp.rs1_data = (byp.rs1_addr == '0) ? '0 : regs[byp.rs1_addr];
    assign byp.rs2_data = (byp.rs2_addr == '0) ? '0 : regs[byp.rs2_addr];
    assign byp.wb_valid = wb_write;
    assign byp.wb_rd    = wb_rd;
    assign byp.wb_data  = wb_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= wb_write;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd_o   <= wb_rd;
        retire_data_o <= wb_data;
    end

endmodule

`default_nettype wire

//--- pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control import core_pkg::*; (
    input  wire    clk,
    input  wire    rst_i,
    input  wire    id_valid_i,
    input  addr_t  id_pc_i,
    input  wire    ds_valid_i,
    input  addr_t  ds_pc_i,
    input  wire    hazard_stall_i,
    input  wire    exe_valid_i,
    input  wire    exe_resolved_i,
    input  addr_t  next_pc_i,
    output logic   id_stall_o,
    output logic   ds_stall_o,
    output logic   exe_stall_o,
    output logic   flush_now_o,
    output logic   flush_last_o,
    output logic   redirect_valid_o,
    output addr_t  redirect_pc_o
);

    addr_t younger_pc;
    logic  younger_valid;

    // EXE holds until a younger instruction shows its PC
    assign exe_stall_o = exe_valid_i && !ds_valid_i && !id_valid_i;
    assign ds_stall_o  = ds_valid_i && (exe_stall_o || hazard_stall_i);
    assign id_stall_o  = id_valid_i && ds_stall_o;

    assign younger_valid = ds_valid_i || id_valid_i;
    assign younger_pc    = ds_valid_i ? ds_pc_i : id_pc_i;

    // fall-through prediction checked against the nearest younger PC
    assign flush_now_o = exe_valid_i && !exe_resolved_i && younger_valid &&
                         (younger_pc != next_pc_i);

    // registered so EXE never reaches the fetch source directly
    always_ff @(posedge clk) begin
        if (rst_i) begin
            redirect_valid_o <= 1'b0;
            redirect_pc_o    <= RESET_PC;
        end else begin
            redirect_valid_o <= flush_now_o;
            redirect_pc_o    <= next_pc_i;
        end
    end

    assign flush_last_o = redirect_valid_o;

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    operand_if.slave   opd,
    input  wire        exe_stall,
    input  wire        flush_now,
    output logic       exe_valid_o,
    output logic       exe_resolved_o,
    output reg_idx_t   exe_rd_o,
    output logic       exe_we_o,
    output addr_t      next_pc_o,
    result_if.master   res
);

    logic      exe_valid;
    logic      exe_resolved;
    addr_t     exe_pc;
    reg_idx_t  exe_rd;
    logic      exe_reg_we;
    alu_op_e   exe_alu_op;
    br_op_e    exe_br_op;
    xlen_t     exe_imm;
    xlen_t     exe_op1;
    xlen_t     exe_op2;
    xlen_t     exe_rs2_val;
    xlen_t     alu_out;
    logic      taken;
    addr_t     target;
    addr_t     seq_pc;

    // bubble when DS holds or its instruction is flushed
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_valid    <= 1'b0;
            exe_resolved <= 1'b0;
            exe_pc       <= RESET_PC;
        end else if (!exe_stall) begin
            exe_valid    <= opd.valid && !flush_now;
            exe_resolved <= 1'b0;
            exe_pc       <= opd.pc;
        end else if (flush_now) begin
            // held branch already redirected
            exe_resolved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!exe_stall) begin
            exe_rd      <= opd.rd;
            exe_reg_we  <= opd.reg_we;
            exe_alu_op  <= opd.alu_op;
            exe_br_op   <= opd.br_op;
            exe_imm     <= opd.imm;
            exe_op1     <= opd.op1;
            exe_op2     <= opd.op2;
            exe_rs2_val <= opd.rs2_val;
        end
    end

    always_comb begin
        case (exe_alu_op)
            ALU_ADD:    alu_out = exe_op1 + exe_op2;
            ALU_SUB:    alu_out = exe_op1 - exe_op2;
            ALU_AND:    alu_out = exe_op1 & exe_op2;
            ALU_OR:     alu_out = exe_op1 | exe_op2;
            ALU_XOR:    alu_out = exe_op1 ^ exe_op2;
            ALU_SLT:    alu_out = {31'b0, $signed(exe_op1) < $signed(exe_op2)};
            ALU_PASS_B: alu_out = exe_op2;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        case (exe_br_op)
            BR_EQ:   taken = (exe_op1 == exe_rs2_val);
            BR_NE:   taken = (exe_op1 != exe_rs2_val);
            BR_LT:   taken = ($signed(exe_op1) < $signed(exe_rs2_val));
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign target    = exe_pc + exe_imm;
    assign seq_pc    = exe_pc + PC_STEP;
    assign next_pc_o = taken ? target : seq_pc;

    // only pass on the cycle EXE actually advances
    assign res.valid  = exe_valid && !exe_stall;
    assign res.rd     = exe_rd;
    assign res.reg_we = exe_reg_we;
    assign res.result = (exe_br_op == BR_JAL) ? seq_pc : alu_out;

    assign exe_valid_o    = exe_valid;
    assign exe_resolved_o = exe_resolved;
    assign exe_rd_o       = exe_rd;
    assign exe_we_o       = exe_valid && exe_reg_we;

endmodule

`default_nettype wire

//--- operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    decode_if.slave    dec,
    input  wire        ds_stall,
    input  wire        flush_now,
    output logic       hazard_stall_o,
    output logic       ds_valid_o,
    output addr_t      ds_pc_o,
    input  reg_idx_t   exe_rd_i,
    input  wire        exe_we_i,
    bypass_if.reader   byp,
    operand_if.master  opd
);

    logic      ds_valid;
    addr_t     ds_pc;
    reg_idx_t  ds_rs1;
    reg_idx_t  ds_rs2;
    reg_idx_t  ds_rd;
    logic      ds_reg_we;
    alu_op_e   ds_alu_op;
    op2_sel_e  ds_op2_sel;
    br_op_e    ds_br_op;
    xlen_t     ds_imm;
    xlen_t     rs1_val;
    xlen_t     rs2_val;

    // ds_stall is never low while ID stalls, so no bubble case here
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ds_valid <= 1'b0;
            ds_pc    <= RESET_PC;
        end else if (flush_now) begin
            ds_valid <= 1'b0;
        end else if (!ds_stall) begin
            ds_valid <= dec.valid;
            ds_pc    <= dec.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!ds_stall) begin
            ds_rs1     <= dec.rs1;
            ds_rs2     <= dec.rs2;
            ds_rd      <= dec.rd;
            ds_reg_we  <= dec.reg_we;
            ds_alu_op  <= dec.alu_op;
            ds_op2_sel <= dec.op2_sel;
            ds_br_op   <= dec.br_op;
            ds_imm     <= dec.imm;
        end
    end

    assign byp.rs1_addr = ds_rs1;
    assign byp.rs2_addr = ds_rs2;

    // WB result is not yet in the array
    assign rs1_val = (byp.wb_valid && byp.wb_rd == ds_rs1 && ds_rs1 != '0) ?
                     byp.wb_data : byp.rs1_data;
    assign rs2_val = (byp.wb_valid && byp.wb_rd == ds_rs2 && ds_rs2 != '0) ?
                     byp.wb_data : byp.rs2_data;

    // no forwarding out of EXE
    assign hazard_stall_o = ds_valid && exe_we_i && (exe_rd_i != '0) &&
                            (exe_rd_i == ds_rs1 || exe_rd_i == ds_rs2);

    // held instruction goes to EXE as a bubble
    assign opd.valid   = ds_valid && !hazard_stall_o;
    assign opd.pc      = ds_pc;
    assign opd.rd      = ds_rd;
    assign opd.reg_we  = ds_reg_we;
    assign opd.alu_op  = ds_alu_op;
    assign opd.br_op   = ds_br_op;
    assign opd.imm     = ds_imm;
    assign opd.op1     = rs1_val;
    assign opd.op2     = (ds_op2_sel == OP2_IMM) ? ds_imm : rs2_val;
    assign opd.rs2_val = rs2_val;

    assign ds_valid_o = ds_valid;
    assign ds_pc_o    = ds_pc;

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        fetch_valid_i,
    input  addr_t      fetch_pc_i,
    input  inst_t      fetch_inst_i,
    output logic       fetch_ready_o,
    input  wire        id_stall,
    input  wire        flush_now,
    input  wire        flush_last,
    output logic       id_valid_o,
    output addr_t      id_pc_o,
    decode_if.master   dec
);

    logic        id_valid;
    addr_t       id_pc;
    inst_t       id_inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    xlen_t       imm_i;
    xlen_t       imm_b;
    xlen_t       imm_j;
    xlen_t       imm_u;
    alu_op_e     f3_op;
    logic        f3_ok;
    logic        we_raw;

    assign fetch_ready_o = !id_stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_valid <= 1'b0;
            id_pc    <= RESET_PC;
            id_inst  <= INST_NOP;
        end else if (flush_now || flush_last) begin
            id_valid <= 1'b0;
        end else if (!id_stall) begin
            id_valid <= fetch_valid_i;
            if (fetch_valid_i) begin
                id_pc   <= fetch_pc_i;
                id_inst <= fetch_inst_i;
            end
        end
    end

    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];
    assign funct7 = id_inst[31:25];
    assign rd     = id_inst[11:7];

    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};
    assign imm_u = {id_inst[31:12], 12'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        f3_ok = 1'b1;
        f3_op = ALU_ADD;
        case (funct3)
            F3_ADD: f3_op = ALU_ADD;
            F3_SLT: f3_op = ALU_SLT;
            F3_XOR: f3_op = ALU_XOR;
            F3_OR:  f3_op = ALU_OR;
            F3_AND: f3_op = ALU_AND;
            default: f3_ok = 1'b0;
        endcase
    end

    // unused source fields stay x0 so they never raise a hazard
    always_comb begin
        we_raw      = 1'b0;
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.alu_op  = ALU_ADD;
        dec.op2_sel = OP2_REG;
        dec.br_op   = BR_NONE;
        dec.imm     = imm_i;
        case (opcode)
            OPC_OP: begin
                dec.rs1    = id_inst[19:15];
                dec.rs2    = id_inst[24:20];
                dec.alu_op = (funct7 == F7_ALT) ? ALU_SUB : f3_op;
                we_raw     = f3_ok && (funct7 == F7_BASE ||
                             (funct7 == F7_ALT && funct3 == F3_ADD));
            end
            OPC_OP_IMM: begin
                dec.rs1     = id_inst[19:15];
                dec.alu_op  = f3_op;
                dec.op2_sel = OP2_IMM;
                we_raw      = f3_ok;
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_PASS_B;
                dec.op2_sel = OP2_IMM;
                dec.imm     = imm_u;
                we_raw      = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                if (funct3 == F3_BEQ || funct3 == F3_BNE || funct3 == F3_BLT) begin
                    dec.rs1 = id_inst[19:15];
                    dec.rs2 = id_inst[24:20];
                end
                case (funct3)
                    F3_BEQ:  dec.br_op = BR_EQ;
                    F3_BNE:  dec.br_op = BR_NE;
                    F3_BLT:  dec.br_op = BR_LT;
                    default: dec.br_op = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec.br_op = BR_JAL;
                dec.imm   = imm_j;
                we_raw    = 1'b1;
            end
            default: ;
        endcase
    end

    assign dec.valid  = id_valid;
    assign dec.pc     = id_pc;
    assign dec.rd     = rd;
    assign dec.reg_we = we_raw && (rd != '0);

    assign id_valid_o = id_valid;
    assign id_pc_o    = id_pc;

endmodule

`default_nettype wire

//--- core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction, ID to DS
interface decode_if import core_pkg::*; ();
    logic     valid;
    addr_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     reg_we;
    alu_op_e  alu_op;
    op2_sel_e op2_sel;
    br_op_e   br_op;
    xlen_t    imm;

    modport master (output valid, pc, rs1, rs2, rd, reg_we, alu_op, op2_sel, br_op, imm);
    modport slave  (input  valid, pc, rs1, rs2, rd, reg_we, alu_op, op2_sel, br_op, imm);
endinterface

// operands ready for EXE
interface operand_if import core_pkg::*; ();
    logic     valid;
    addr_t    pc;
    reg_idx_t rd;
    logic     reg_we;
    alu_op_e  alu_op;
    br_op_e   br_op;
    xlen_t    imm;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    rs2_val;

    modport master (output valid, pc, rd, reg_we, alu_op, br_op, imm, op1, op2, rs2_val);
    modport slave  (input  valid, pc, rd, reg_we, alu_op, br_op, imm, op1, op2, rs2_val);
endinterface

interface result_if import core_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     reg_we;
    xlen_t    result;

    modport master (output valid, rd, reg_we, result);
    modport slave  (input  valid, rd, reg_we, result);
endinterface

// WB forwarding plus the two register read ports
interface bypass_if import core_pkg::*; ();
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    modport owner  (output wb_valid, wb_rd, wb_data, rs1_data, rs2_data,
                    input  rs1_addr, rs2_addr);
    modport reader (input  wb_valid, wb_rd, wb_data, rs1_data, rs2_data,
                    output rs1_addr, rs2_addr);
endinterface

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JAL
    } br_op_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;
    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t PC_STEP  = 32'd4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;

    // funct7 of the register-register ops, alt selects SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire
